// File: Bender.yml
package:
  name: ldpc_vnode

sources:
  # packages first, the rest depends on them
  - common/ldpc_dec_cfg_pkg.sv
  - common/ldpc_dec_types_pkg.sv
  # variable node blocks
  - ldpc_vnode/ldpc_vnode_sum.sv
  - ldpc_vnode/ldpc_vnode_restore.sv
  - ldpc_vnode/ldpc_vnode_state_ram.sv
  # top level
  - rtl/ldpc_vnode_top.sv
  # testbench
  - target: test
    files:
      - test/tb_ldpc_vnode.sv

// File: common/ldpc_dec_cfg_pkg.sv
package ldpc_dec_cfg_pkg;

  // --------------------
  // datapath widths
  // --------------------

  localparam int cLLR_W      = 4;  // channel llr
  localparam int cNODE_W     = 8;  // check/variable message

  // column sum holds llr plus cCOL_DEG messages without wrap
  localparam int cNODE_SUM_W = cNODE_W + 3;

  // --------------------
  // code geometry
  // --------------------

  localparam int cCOL_DEG     = 4;                  // edges per column
  localparam int cEDGE_NUM    = 64;                 // edges held by state memory
  localparam int cEDGE_ADDR_W = $clog2(cEDGE_NUM);  // 6

  // symmetric saturation, most negative code never leaves
  localparam int cNODE_MAX   = (1 << (cNODE_W - 1)) - 1;

endpackage

// File: common/ldpc_dec_types_pkg.sv
package ldpc_dec_types_pkg;

  import ldpc_dec_cfg_pkg::*;

  // --------------------
  // signed datapath values
  // --------------------

  typedef logic signed [cLLR_W-1:0]      llr_t;       // channel llr
  typedef logic signed [cNODE_W-1:0]     node_t;      // single edge message
  typedef logic signed [cNODE_SUM_W-1:0] node_sum_t;  // full column sum

  // --------------------
  // indexes
  // --------------------

  typedef logic [cEDGE_ADDR_W-1:0]      cycle_idx_t;  // edge address
  typedef logic [$clog2(cCOL_DEG)-1:0]  deg_idx_t;    // edge inside column

  // self-correction memory per edge
  typedef struct packed {
    logic pre_sign;  // sign of last passed message
    logic pre_zero;  // last message zeroed or first iteration
  } node_state_t;

  // state of an edge never written in this iteration
  localparam node_state_t cSTATE_INIT = '{pre_sign: 1'b0, pre_zero: 1'b1};

endpackage

// File: compile.f
common/ldpc_dec_cfg_pkg.sv
common/ldpc_dec_types_pkg.sv
ldpc_vnode/ldpc_vnode_sum.sv
ldpc_vnode/ldpc_vnode_restore.sv
ldpc_vnode/ldpc_vnode_state_ram.sv
rtl/ldpc_vnode_top.sv
test/tb_ldpc_vnode.sv

// File: ldpc_vnode/ldpc_vnode_restore.sv
`timescale 1ns/1ps

module ldpc_vnode_restore #(
  parameter bit use_sc_mode = 1'b1
) (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iclkena,
  input  logic                            istate_init,
  input  logic                            ival,
  input  ldpc_dec_types_pkg::cycle_idx_t  ivnode_addr,
  input  ldpc_dec_types_pkg::node_state_t ivnode_state,
  input  ldpc_dec_types_pkg::node_t       icnode,
  input  ldpc_dec_types_pkg::node_sum_t   ivnode_sum,
  input  logic                            ivnode_hd,
  output logic                            ovnode_val,
  output ldpc_dec_types_pkg::cycle_idx_t  ovnode_addr,
  output ldpc_dec_types_pkg::node_t       ovnode,
  output logic                            ovnode_hd,
  output ldpc_dec_types_pkg::node_state_t ovnode_state
);

  import ldpc_dec_cfg_pkg::*;
  import ldpc_dec_types_pkg::*;

  logic [1:0]  val;          // valid shift, two stages

  node_sum_t   vnode;        // extrinsic, full width
  logic        vnode_hd;
  cycle_idx_t  vnode_addr;
  node_state_t vnode_state;

  logic        vnode_sign;
  logic        sc_flip;      // sign flipped against a live state

  // --------------------
  // saturation to +-cNODE_MAX
  // --------------------

  function automatic node_t saturate(input node_sum_t dat);
    node_t res;
    if (dat > cNODE_MAX) begin
      res = node_t'(cNODE_MAX);
    end else if (dat < -cNODE_MAX) begin
      res = node_t'(-cNODE_MAX);  // -128 folds to -127
    end else begin
      res = node_t'(dat);
    end
    return res;
  endfunction

  // --------------------
  // pipeline
  // --------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val <= '0;
    end else if (iclkena) begin
      val <= {val[0], ival};
    end
  end

  assign ovnode_val = val[1];

  assign vnode_sign = vnode[cNODE_SUM_W-1];

  // first iteration never zeroes, zeroed edges pass next time
  assign sc_flip = use_sc_mode && !istate_init && !vnode_state.pre_zero &&
                   (vnode_state.pre_sign ^ vnode_sign);

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      // stage 1, drop own message
      vnode       <= ivnode_sum - icnode;
      vnode_hd    <= ivnode_hd;
      vnode_addr  <= ivnode_addr;
      vnode_state <= ivnode_state;
      // stage 2, saturate and correct
      ovnode_hd   <= vnode_hd;
      ovnode_addr <= vnode_addr;
      ovnode      <= sc_flip ? '0 : saturate(vnode);
      if (istate_init || sc_flip) begin
        ovnode_state <= cSTATE_INIT;
      end else begin
        ovnode_state <= '{pre_sign: vnode_sign, pre_zero: 1'b0};
      end
    end
  end

  // output range stays symmetric
  a_no_min_code : assert property (@(posedge iclk) disable iff (ireset)
    ovnode_val |-> (ovnode >= -cNODE_MAX))
    else $error("ovnode carries the most negative code %0d", ovnode);

endmodule

// File: ldpc_vnode/ldpc_vnode_state_ram.sv
`timescale 1ns/1ps

module ldpc_vnode_state_ram (
  input  logic                            iclk,
  input  logic                            ireset,
  input  logic                            iwrite,
  input  ldpc_dec_types_pkg::cycle_idx_t  iwaddr,
  input  ldpc_dec_types_pkg::node_state_t iwstate,
  input  ldpc_dec_types_pkg::cycle_idx_t  iraddr,
  output ldpc_dec_types_pkg::node_state_t ordstate
);

  import ldpc_dec_cfg_pkg::*;
  import ldpc_dec_types_pkg::*;

  node_state_t          mem [cEDGE_NUM];  // per edge sc state
  logic [cEDGE_NUM-1:0] valid;            // entry written since reset

  // --------------------
  // write port
  // --------------------

  always_ff @(posedge iclk) begin
    if (iwrite) begin
      mem[iwaddr] <= iwstate;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      valid <= '0;
    end else if (iwrite) begin
      valid[iwaddr] <= 1'b1;
    end
  end

  // --------------------
  // read port
  // --------------------

  // async read, same cycle write shows old data
  assign ordstate = valid[iraddr] ? mem[iraddr] : cSTATE_INIT;

  a_waddr_known : assert property (@(posedge iclk) disable iff (ireset)
    iwrite |-> !$isunknown(iwaddr))
    else $error("state write with unknown address");

endmodule

// File: ldpc_vnode/ldpc_vnode_sum.sv
`timescale 1ns/1ps

module ldpc_vnode_sum (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           iclkena,
  input  logic                           ival,
  input  logic                           istart,
  input  ldpc_dec_types_pkg::llr_t       illr,
  input  ldpc_dec_types_pkg::node_t      icnode,
  input  ldpc_dec_types_pkg::cycle_idx_t iaddr,
  output logic                           orep_val,
  output ldpc_dec_types_pkg::cycle_idx_t orep_addr,
  output ldpc_dec_types_pkg::node_t      orep_cnode,
  output ldpc_dec_types_pkg::node_sum_t  orep_sum,
  output logic                           orep_hd
);

  import ldpc_dec_cfg_pkg::*;
  import ldpc_dec_types_pkg::*;

  // ping-pong edge buffer, one bank per column
  node_t      cnode_buf [2][cCOL_DEG];
  cycle_idx_t addr_buf  [2][cCOL_DEG];

  logic       wr_bank;   // bank being filled
  deg_idx_t   wr_cnt;    // edge inside incoming column
  node_sum_t  acc;       // running column sum
  node_sum_t  acc_nxt;
  logic       wr_last;   // last edge of column this cycle

  logic       col_done;  // finished column, one cycle pulse
  node_sum_t  col_sum;
  logic       col_hd;

  logic       rd_bank;   // bank being replayed
  deg_idx_t   rd_cnt;
  logic       rd_busy;   // replay edges 1..cCOL_DEG-1 pending
  deg_idx_t   rd_idx;

  // --------------------
  // accumulate
  // --------------------

  // llr seeds the sum on the first edge
  assign acc_nxt = (istart ? node_sum_t'(illr) : acc) + node_sum_t'(icnode);
  assign wr_last = ival && (wr_cnt == deg_idx_t'(cCOL_DEG - 1));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_bank  <= 1'b0;
      wr_cnt   <= '0;
      col_done <= 1'b0;
    end else if (iclkena) begin
      col_done <= wr_last;
      if (ival) begin
        wr_cnt <= wr_last ? '0 : wr_cnt + 1'b1;
      end
      if (wr_last) begin
        wr_bank <= ~wr_bank;  // next column into other bank
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (ival) begin
        cnode_buf[wr_bank][wr_cnt] <= icnode;
        addr_buf[wr_bank][wr_cnt]  <= iaddr;
        acc                        <= acc_nxt;
      end
      if (wr_last) begin
        col_sum <= acc_nxt;
        col_hd  <= acc_nxt[cNODE_SUM_W-1];  // negative sum -> bit 1
      end
    end
  end

  // --------------------
  // replay
  // --------------------

  assign rd_idx = col_done ? '0 : rd_cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      orep_val <= 1'b0;
      rd_bank  <= 1'b0;
      rd_cnt   <= '0;
      rd_busy  <= 1'b0;
    end else if (iclkena) begin
      orep_val <= col_done || rd_busy;
      if (wr_last) begin
        rd_bank <= wr_bank;  // old bank still read this edge
      end
      if (col_done) begin
        rd_busy <= 1'b1;
        rd_cnt  <= deg_idx_t'(1);
      end else if (rd_busy) begin
        rd_cnt <= rd_cnt + 1'b1;  // wraps back to zero
        if (rd_cnt == deg_idx_t'(cCOL_DEG - 1)) begin
          rd_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && (col_done || rd_busy)) begin
      orep_cnode <= cnode_buf[rd_bank][rd_idx];
      orep_addr  <= addr_buf[rd_bank][rd_idx];
      if (col_done) begin
        orep_sum <= col_sum;  // held for the whole column
        orep_hd  <= col_hd;
      end
    end
  end

  // column framing, istart only on edge 0 of a column
  a_start_aligned : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && istart) |-> (ival && (wr_cnt == '0)))
    else $error("istart seen in the middle of a column or without ival");

endmodule

// File: rtl/ldpc_vnode_top.sv
`timescale 1ns/1ps

module ldpc_vnode_top #(
  parameter bit use_sc_mode = 1'b1
) (
  input  logic                           iclk,
  input  logic                           ireset,
  input  logic                           iclkena,
  input  logic                           istate_init,
  input  logic                           ival,
  input  logic                           istart,
  input  ldpc_dec_types_pkg::llr_t       illr,
  input  ldpc_dec_types_pkg::node_t      icnode,
  input  ldpc_dec_types_pkg::cycle_idx_t iaddr,
  output logic                           ovnode_val,
  output ldpc_dec_types_pkg::cycle_idx_t ovnode_addr,
  output ldpc_dec_types_pkg::node_t      ovnode,
  output logic                           ovnode_hd
);

  import ldpc_dec_types_pkg::*;

  // replay stream, sum -> restore
  logic        rep_val;
  cycle_idx_t  rep_addr;
  node_t       rep_cnode;
  node_sum_t   rep_sum;
  logic        rep_hd;

  // self-correction loop
  node_state_t rd_state;
  node_state_t wr_state;
  logic        state_write;

  // stalled cycle must not rewrite state
  assign state_write = ovnode_val & iclkena;

  // --------------------
  // column sum and replay
  // --------------------

  ldpc_vnode_sum u_sum (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .ival       (ival),
    .istart     (istart),
    .illr       (illr),
    .icnode     (icnode),
    .iaddr      (iaddr),
    .orep_val   (rep_val),
    .orep_addr  (rep_addr),
    .orep_cnode (rep_cnode),
    .orep_sum   (rep_sum),
    .orep_hd    (rep_hd)
  );

  ldpc_vnode_state_ram u_state_ram (
    .iclk     (iclk),
    .ireset   (ireset),
    .iwrite   (state_write),
    .iwaddr   (ovnode_addr),
    .iwstate  (wr_state),
    .iraddr   (rep_addr),   // read lines up with replay
    .ordstate (rd_state)
  );

  // --------------------
  // extrinsic restore
  // --------------------

  ldpc_vnode_restore #(
    .use_sc_mode (use_sc_mode)
  ) u_restore (
    .iclk         (iclk),
    .ireset       (ireset),
    .iclkena      (iclkena),
    .istate_init  (istate_init),
    .ival         (rep_val),
    .ivnode_addr  (rep_addr),
    .ivnode_state (rd_state),
    .icnode       (rep_cnode),
    .ivnode_sum   (rep_sum),
    .ivnode_hd    (rep_hd),
    .ovnode_val   (ovnode_val),
    .ovnode_addr  (ovnode_addr),
    .ovnode       (ovnode),
    .ovnode_hd    (ovnode_hd),
    .ovnode_state (wr_state)
  );

endmodule

// File: test/tb_ldpc_vnode.sv
`timescale 1ns/1ps

module tb_ldpc_vnode;

  import ldpc_dec_cfg_pkg::*;
  import ldpc_dec_types_pkg::*;

  localparam int cLAT     = cCOL_DEG + 3;  // enabled cycles entry to exit
  localparam int cCOL_NUM = 8;             // columns per pass
  localparam int cTIMEOUT = 2000;          // cycles per wait loop

  typedef struct {
    node_t       node;
    logic        hd;
    cycle_idx_t  addr;
    int unsigned exit_cnt;  // enabled cycle of the output edge
  } exp_t;

  logic       iclk = 1'b0;
  logic       ireset;
  logic       iclkena;
  logic       istate_init;
  logic       ival;
  logic       istart;
  llr_t       illr;
  node_t      icnode;
  cycle_idx_t iaddr;
  logic       ovnode_val;
  cycle_idx_t ovnode_addr;
  node_t      ovnode;
  logic       ovnode_hd;

  exp_t        exp_q [$];         // reference model queue
  logic        exp_valid;
  node_t       exp_node;
  logic        exp_hd;
  cycle_idx_t  exp_addr;
  int unsigned exp_exit;
  int unsigned ena_cnt;           // enabled edges since reset
  int          stall_pct;         // chance of iclkena low, percent
  logic        m_sign [cEDGE_NUM];  // model sc state
  logic        m_zero [cEDGE_NUM];
  int          err_value;
  int          err_other;

  always #4 iclk = ~iclk;  // 8 ns period

  ldpc_vnode_top #(
    .use_sc_mode (1'b1)
  ) DUT (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .istate_init (istate_init),
    .ival        (ival),
    .istart      (istart),
    .illr        (illr),
    .icnode      (icnode),
    .iaddr       (iaddr),
    .ovnode_val  (ovnode_val),
    .ovnode_addr (ovnode_addr),
    .ovnode      (ovnode),
    .ovnode_hd   (ovnode_hd)
  );

  // --------------------
  // reference model
  // --------------------

  function automatic node_t clamp_msg(input int v);
    if (v > cNODE_MAX) begin
      return node_t'(cNODE_MAX);
    end
    if (v < -cNODE_MAX) begin
      return node_t'(-cNODE_MAX);
    end
    return node_t'(v);
  endfunction

  function automatic void update_front();
    exp_valid = (exp_q.size() > 0);
    if (exp_valid) begin
      exp_node = exp_q[0].node;
      exp_hd   = exp_q[0].hd;
      exp_addr = exp_q[0].addr;
      exp_exit = exp_q[0].exit_cnt;
    end
  endfunction

  // output consumed on an enabled edge only
  always @(posedge iclk) begin
    if (!ireset && iclkena) begin
      ena_cnt <= ena_cnt + 1;
      if (ovnode_val && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        update_front();
      end
    end
  end

  task automatic abort(input string why);
    $display("%s at %0t", why, $time);
    $display("errors: %0d value, %0d other", err_value, err_other);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // --------------------
  // stimulus
  // --------------------

  // holds the edge until an enabled cycle takes it
  task automatic drive_edge(input logic start, input llr_t llr, input node_t m,
                            input cycle_idx_t a, input node_t enode, input logic ehd);
    exp_t e;
    int   tries;
    tries = 0;
    do begin
      @(posedge iclk);
      #1;
      iclkena = ($urandom_range(99) >= stall_pct);
      ival    = 1'b1;
      istart  = start;
      illr    = llr;
      icnode  = m;
      iaddr   = a;
      tries++;
      if (tries > cTIMEOUT) abort("clock enable stayed low while an edge was waiting");
    end while (!iclkena);
    e = '{node: enode, hd: ehd, addr: a, exit_cnt: ena_cnt + cLAT};
    exp_q.push_back(e);
    update_front();
  endtask

  task automatic idle_cycle();
    @(posedge iclk);
    #1;
    iclkena = ($urandom_range(99) >= stall_pct);
    ival    = 1'b0;
    istart  = 1'b0;
  endtask

  task automatic send_column(input int col, input bit big);
    llr_t       llr;
    node_t      m [cCOL_DEG];
    cycle_idx_t a [cCOL_DEG];
    node_t      enode;
    int         sum;
    int         ext;
    logic       neg;
    logic       sgn;
    llr = llr_t'($urandom_range(15));
    neg = $urandom_range(1);
    sum = llr;
    for (int j = 0; j < cCOL_DEG; j++) begin
      if (big) begin  // one sign, large magnitudes
        m[j] = neg ? node_t'(-int'($urandom_range(128, 90))) : node_t'($urandom_range(127, 90));
      end else begin
        m[j] = node_t'($urandom_range(255));
      end
      sum += m[j];
      a[j] = cycle_idx_t'((col * cCOL_DEG + j) * 5);  // odd stride, still unique
    end
    for (int j = 0; j < cCOL_DEG; j++) begin
      ext = sum - m[j];  // extrinsic, own message removed
      sgn = (ext < 0);
      if (!istate_init && !m_zero[a[j]] && (m_sign[a[j]] != sgn)) begin
        enode       = '0;  // sign flip against live state
        m_sign[a[j]] = 1'b0;
        m_zero[a[j]] = 1'b1;
      end else begin
        enode        = clamp_msg(ext);
        m_sign[a[j]] = istate_init ? 1'b0 : sgn;
        m_zero[a[j]] = istate_init;
      end
      drive_edge(j == 0, llr, m[j], a[j], enode, sum < 0);
    end
    if (stall_pct > 0) begin
      repeat ($urandom_range(2)) idle_cycle();  // optional gap between columns
    end
  endtask

  task automatic drain();
    int tries;
    tries = 0;
    while (exp_q.size() > 0) begin
      idle_cycle();
      tries++;
      if (tries > cTIMEOUT) abort("output edges missing, model queue never drained");
    end
  endtask

  task automatic run_pass(input logic init, input int stall, input bit big);
    istate_init = init;
    stall_pct   = stall;
    for (int c = 0; c < cCOL_NUM; c++) begin
      send_column(c, big);
    end
    drain();
  endtask

  // --------------------
  // checks
  // --------------------

  a_has_exp : assert property (@(posedge iclk) disable iff (ireset)
    (ovnode_val && iclkena) |-> exp_valid)
    else begin
      err_other++;
      $display("output edge at %0t with no edge pending in the model", $time);
    end

  a_node : assert property (@(posedge iclk) disable iff (ireset)
    (ovnode_val && iclkena && exp_valid) |-> (ovnode == exp_node))
    else begin
      err_value++;
      $display("** Error at %0t: ovnode expected %0d got %0d",
               $time, $sampled(exp_node), $sampled(ovnode));
    end

  a_hd : assert property (@(posedge iclk) disable iff (ireset)
    (ovnode_val && iclkena && exp_valid) |-> (ovnode_hd == exp_hd))
    else begin
      err_value++;
      $display("** Error at %0t: ovnode_hd expected %0b got %0b",
               $time, $sampled(exp_hd), $sampled(ovnode_hd));
    end

  a_addr : assert property (@(posedge iclk) disable iff (ireset)
    (ovnode_val && iclkena && exp_valid) |-> (ovnode_addr == exp_addr))
    else begin
      err_value++;
      $display("** Error at %0t: ovnode_addr expected %0d got %0d",
               $time, $sampled(exp_addr), $sampled(ovnode_addr));
    end

  // 7 enabled cycles, so no gaps when columns run back to back
  a_latency : assert property (@(posedge iclk) disable iff (ireset)
    (ovnode_val && iclkena && exp_valid) |-> (ena_cnt == exp_exit))
    else begin
      err_other++;
      $display("edge left at enabled cycle %0d instead of %0d, time %0t",
               $sampled(ena_cnt), $sampled(exp_exit), $time);
    end

  a_stall_val : assert property (@(posedge iclk) disable iff (ireset)
    !iclkena |=> $stable(ovnode_val))
    else begin
      err_other++;
      $display("ovnode_val moved during a stall at %0t", $time);
    end

  a_stall_data : assert property (@(posedge iclk) disable iff (ireset)
    (!iclkena && ovnode_val) |=> $stable({ovnode, ovnode_addr, ovnode_hd}))
    else begin
      err_other++;
      $display("output data moved during a stall at %0t", $time);
    end

  // --------------------
  // main sequence
  // --------------------

  initial begin
    void'($urandom(32'hd001a9b7));
    ireset      = 1'b1;
    iclkena     = 1'b1;
    istate_init = 1'b1;
    ival        = 1'b0;
    istart      = 1'b0;
    illr        = '0;
    icnode      = '0;
    iaddr       = '0;
    exp_valid   = 1'b0;
    ena_cnt     = 0;
    stall_pct   = 0;
    err_value   = 0;
    err_other   = 0;
    for (int i = 0; i < cEDGE_NUM; i++) begin
      m_sign[i] = 1'b0;
      m_zero[i] = 1'b1;  // matches memory after reset
    end
    repeat (3) @(posedge iclk);
    #1;
    ireset = 1'b0;

    run_pass(1'b1, 0, 1'b0);   // first iteration, back to back columns
    run_pass(1'b0, 0, 1'b0);   // states go live, nothing zeroed yet
    run_pass(1'b0, 30, 1'b0);  // flips zeroed, random stalls
    run_pass(1'b0, 30, 1'b0);  // zeroed edges pass their new value
    run_pass(1'b1, 25, 1'b1);  // saturation at +-127

    repeat (4) idle_cycle();
    $display("errors: %0d value, %0d other", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
